/* build.f */
+incdir+dv
hw/axil_pkg.sv
hw/timer_regmap_pkg.sv
hw/axil_resp_slot.sv
hw/axil_slave_fsm.sv
hw/timer_regs.sv
hw/axil_timer_top.sv
dv/tb_axil_timer.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_axil_timer
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* dv/axil_master_tasks.svh */
// Compare tasks, one per kind of result
task automatic check_resp(input string what, input axil_resp_t exp, input axil_resp_t act);
    if (exp !== act) begin
        fail_and_stop($sformatf("error %s %s: expected %s, actual %s (%b)",
                                test_name, what, exp.name(), act.name(), act));
    end
endtask

task automatic check_data(input string what, input logic [AXIL_DATA_W-1:0] exp,
                          input logic [AXIL_DATA_W-1:0] act);
    if (exp !== act) begin
        fail_and_stop($sformatf("error %s %s: expected %h, actual %h",
                                test_name, what, exp, act));
    end
endtask

task automatic check_irq_gap(input string what, input int exp, input int act);
    if (exp != act) begin
        fail_and_stop($sformatf("error %s %s: expected %0d, actual %0d",
                                test_name, what, exp, act));
    end
endtask

// Address and data valid held together until both readies pulse
task automatic axil_write(input logic [AXIL_ADDR_W-1:0] addr, input logic [AXIL_DATA_W-1:0] data,
                          input int stall, output axil_resp_t resp);
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    @(negedge aclk);
    while (!(awready && wready)) @(negedge aclk);
    @(negedge aclk);                                     // Handshake edge is behind us
    awvalid = 1'b0;
    wvalid  = 1'b0;
    while (!bvalid) @(negedge aclk);
    resp = axil_resp_t'(bresp);
    repeat (stall) begin
        @(negedge aclk);                                 // Response must sit still
        if (!bvalid) fail_and_stop("bvalid dropped before bready was given");
        check_resp("held bresp", resp, axil_resp_t'(bresp));
    end
    bready = 1'b1;
    @(negedge aclk);
    bready = 1'b0;
    if (bvalid) fail_and_stop("bvalid still high after the response was accepted");
endtask

task automatic axil_read(input logic [AXIL_ADDR_W-1:0] addr, input int stall,
                         output logic [AXIL_DATA_W-1:0] data, output axil_resp_t resp);
    araddr  = addr;
    arvalid = 1'b1;
    @(negedge aclk);
    while (!arready) @(negedge aclk);
    @(negedge aclk);
    arvalid = 1'b0;
    while (!rvalid) @(negedge aclk);
    data = rdata;                                        // First look at the response
    resp = axil_resp_t'(rresp);
    repeat (stall) begin
        @(negedge aclk);
        if (!rvalid) fail_and_stop("rvalid dropped before rready was given");
        check_data("held rdata", data, rdata);
        check_resp("held rresp", resp, axil_resp_t'(rresp));
    end
    rready = 1'b1;
    @(negedge aclk);
    rready = 1'b0;
    if (rvalid) fail_and_stop("rvalid still high after the response was accepted");
endtask

// Shorthands that check the response against what the test expects
task automatic write_expect(input logic [AXIL_ADDR_W-1:0] addr, input logic [AXIL_DATA_W-1:0] data,
                            input int stall, input axil_resp_t exp_resp);
    axil_resp_t resp;
    axil_write(addr, data, stall, resp);
    check_resp("bresp", exp_resp, resp);
endtask

task automatic read_expect(input logic [AXIL_ADDR_W-1:0] addr, input logic [AXIL_DATA_W-1:0] exp,
                           input int stall, input axil_resp_t exp_resp);
    logic [AXIL_DATA_W-1:0] data;
    axil_resp_t             resp;
    axil_read(addr, stall, data, resp);
    check_resp("rresp", exp_resp, resp);
    check_data("rdata", exp, data);
endtask

/* dv/tb_axil_timer.sv */
`timescale 1ns/1ps

module tb_axil_timer import axil_pkg::*, timer_regmap_pkg::*; ();

    localparam logic [AXIL_ADDR_W-1:0] BASE_ADDR = '0;
    localparam int XFER_BUDGET     = 400;              // Upper bound on transfers in all tests
    localparam int XFER_CYCLES     = 40;               // Twice a handshake with two 8-cycle stalls
    localparam int IRQ_CYCLES      = 4000;             // Pulse counting and quiet window
    localparam int WATCHDOG_CYCLES = XFER_BUDGET * XFER_CYCLES + IRQ_CYCLES;

    logic                   aclk = 1'b0;
    logic                   aresetn;
    logic [AXIL_ADDR_W-1:0] araddr;
    logic                   arvalid;
    logic                   arready;
    logic [AXIL_DATA_W-1:0] rdata;
    logic [1:0]             rresp;
    logic                   rvalid;
    logic                   rready;
    logic [AXIL_ADDR_W-1:0] awaddr;
    logic                   awvalid;
    logic                   awready;
    logic [AXIL_DATA_W-1:0] wdata;
    logic                   wvalid;
    logic                   wready;
    logic [1:0]             bresp;
    logic                   bvalid;
    logic                   bready;
    logic                   irq;
    string                  test_name;                 // Shown in every error line

    always #10 aclk = ~aclk;                           // 20 ns period

    axil_timer_top #(.BASE_ADDR(BASE_ADDR)) axil_timer_top_inst (.*);

    task automatic fail_and_stop(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "run stopped at the first failure");
    endtask

`include "axil_master_tasks.svh"

    task automatic test_reset_roundtrip();
        logic [AXIL_DATA_W-1:0] word;
        test_name = "reset_roundtrip";
        for (int i = 0; i < 4; i++) begin
            read_expect(BASE_ADDR + 32'(4 * i), '0, 0, OKAY);  // All four words clear
        end
        for (int i = 0; i < 8; i++) begin
            word = $urandom;
            write_expect(BASE_ADDR + REG_DATA_1, word, 0, OKAY);
            read_expect(BASE_ADDR + REG_DATA_1, word, 0, OKAY);
            word = $urandom;
            write_expect(BASE_ADDR + REG_DATA_0, word, 0, OKAY);
            read_expect(BASE_ADDR + REG_DATA_0, word, 0, OKAY);
        end
    endtask

    task automatic test_decode_errors();
        logic [AXIL_ADDR_W-1:0] bad_addr [3];
        logic [AXIL_DATA_W-1:0] keep;
        test_name = "decode_errors";
        bad_addr = '{32'h10, 32'hFFC, 32'h2};          // Past the window, far off, unaligned
        keep = $urandom;
        write_expect(BASE_ADDR + REG_DATA_1, keep, 0, OKAY);
        foreach (bad_addr[i]) begin
            write_expect(BASE_ADDR + bad_addr[i], $urandom, 0, SLVERR);
            read_expect(BASE_ADDR + bad_addr[i], '0, 0, SLVERR);
        end
        read_expect(BASE_ADDR + REG_DATA_1, keep, 0, OKAY);    // Scratch untouched
    endtask

    task automatic test_back_pressure();
        logic [AXIL_DATA_W-1:0] word;
        logic [AXIL_ADDR_W-1:0] addr;
        test_name = "back_pressure";
        for (int i = 0; i < 150; i++) begin
            addr = BASE_ADDR + ((i % 2 == 0) ? REG_DATA_1 : REG_DATA_0);
            word = $urandom;
            write_expect(addr, word, int'($urandom % 9), OKAY);    // Stall 0 to 8 cycles
            read_expect(addr, word, int'($urandom % 9), OKAY);
        end
    endtask

    task automatic test_counter_control();
        logic [AXIL_DATA_W-1:0] first;
        logic [AXIL_DATA_W-1:0] second;
        axil_resp_t             resp;
        test_name = "counter_control";
        write_expect(BASE_ADDR + REG_CONTROL, '0, 0, OKAY);
        write_expect(BASE_ADDR + REG_STATUS, 32'h55, 0, OKAY);
        read_expect(BASE_ADDR + REG_STATUS, 32'h55, 0, OKAY);  // Held while disabled
        read_expect(BASE_ADDR + REG_STATUS, 32'h55, 0, OKAY);
        write_expect(BASE_ADDR + REG_DATA_0, 32'hFFFF_FFFF, 0, OKAY);
        write_expect(BASE_ADDR + REG_CONTROL, 32'h1 << CTRL_ENABLE, 0, OKAY);
        axil_read(BASE_ADDR + REG_STATUS, 0, first, resp);
        check_resp("rresp", OKAY, resp);
        axil_read(BASE_ADDR + REG_STATUS, 0, second, resp);
        check_resp("rresp", OKAY, resp);
        if (second <= first) begin
            fail_and_stop($sformatf("error %s running status: expected above %h, actual %h",
                                    test_name, first, second));
        end
        write_expect(BASE_ADDR + REG_CONTROL, '0, 0, OKAY);
        axil_read(BASE_ADDR + REG_STATUS, 0, first, resp);
        check_resp("rresp", OKAY, resp);
        axil_read(BASE_ADDR + REG_STATUS, 0, second, resp);
        check_resp("rresp", OKAY, resp);
        check_data("frozen status", first, second);
    endtask

    task automatic test_period_wrap();
        int gap;
        int width;
        int pulses;
        test_name = "period_wrap";
        write_expect(BASE_ADDR + REG_DATA_0, 32'd9, 0, OKAY);
        write_expect(BASE_ADDR + REG_STATUS, '0, 0, OKAY);
        write_expect(BASE_ADDR + REG_CONTROL,
                     (32'h1 << CTRL_ENABLE) | (32'h1 << CTRL_IRQ_EN), 0, OKAY);
        while (!irq) @(negedge aclk);
        for (int p = 0; p < 5; p++) begin
            gap   = 0;
            width = 0;
            while (irq) begin
                width++;
                gap++;
                @(negedge aclk);
            end
            check_irq_gap("irq pulse width", 1, width);
            while (!irq) begin
                gap++;
                @(negedge aclk);
            end
            check_irq_gap("edges between irq pulses", 10, gap);    // Period plus one
        end
        write_expect(BASE_ADDR + REG_CONTROL, 32'h1 << CTRL_ENABLE, 0, OKAY);
        pulses = 0;
        repeat (50) begin
            @(negedge aclk);
            if (irq) pulses++;
        end
        check_irq_gap("irq pulses with irq enable clear", 0, pulses);
        write_expect(BASE_ADDR + REG_CONTROL, '0, 0, OKAY);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge aclk);
        fail_and_stop($sformatf("watchdog expired after %0d cycles, the tests did not finish",
                                WATCHDOG_CYCLES));
    end

    initial begin
        void'($urandom(32'h9efa45cb));
        test_name  = "reset";
        aresetn    = 1'b0;
        araddr     = '0;
        arvalid    = 1'b0;
        rready     = 1'b0;
        awaddr     = '0;
        awvalid    = 1'b0;
        wdata      = '0;
        wvalid     = 1'b0;
        bready     = 1'b0;
        repeat (10) @(negedge aclk);
        aresetn = 1'b1;
        @(negedge aclk);
        test_reset_roundtrip();
        test_decode_errors();
        test_back_pressure();
        test_counter_control();
        test_period_wrap();
        $display("Simulation passed");
        $finish;
    end

endmodule

/* hw/axil_timer_top.sv */
`timescale 1ns/1ps

module axil_timer_top import axil_pkg::*; #(
    parameter logic [AXIL_ADDR_W-1:0] BASE_ADDR = '0   // Register window base
) (
    input  logic                   aclk,       // Bus clock
    input  logic                   aresetn,    // Async reset, active low
    input  logic [AXIL_ADDR_W-1:0] araddr,     // Read address
    input  logic                   arvalid,    // Read address valid
    output logic                   arready,    // Read address ready
    output logic [AXIL_DATA_W-1:0] rdata,      // Read data
    output logic [1:0]             rresp,      // Read response
    output logic                   rvalid,     // Read data valid
    input  logic                   rready,     // Read data ready
    input  logic [AXIL_ADDR_W-1:0] awaddr,     // Write address
    input  logic                   awvalid,    // Write address valid
    output logic                   awready,    // Write address ready
    input  logic [AXIL_DATA_W-1:0] wdata,      // Write data
    input  logic                   wvalid,     // Write data valid
    output logic                   wready,     // Write data ready
    output logic [1:0]             bresp,      // Write response
    output logic                   bvalid,     // Write response valid
    input  logic                   bready,     // Write response ready
    output logic                   irq         // Timer wrap interrupt
);

    logic                   rd_strobe;         // FSM to bank read
    logic [AXIL_ADDR_W-1:0] rd_addr;
    logic [AXIL_DATA_W-1:0] rd_data;
    logic                   rd_err;
    logic                   wr_strobe;         // FSM to bank write
    logic [AXIL_ADDR_W-1:0] wr_addr;
    logic [AXIL_DATA_W-1:0] wr_data;
    logic                   wr_err;
    logic                   r_load;            // FSM to read slot
    axil_r_payload_t        r_payload;
    logic                   r_busy;
    axil_r_payload_t        r_bus;             // Read slot to the bus
    logic                   b_load;            // FSM to write slot
    axil_b_payload_t        b_payload;
    logic                   b_busy;
    axil_b_payload_t        b_bus;             // Write slot to the bus

    axil_slave_fsm axil_slave_fsm_inst (
        .aclk(aclk), .aresetn(aresetn),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wvalid(wvalid), .wready(wready),
        .rd_strobe(rd_strobe), .rd_addr(rd_addr), .rd_data(rd_data), .rd_err(rd_err),
        .r_load(r_load), .r_payload(r_payload), .r_busy(r_busy),
        .wr_strobe(wr_strobe), .wr_addr(wr_addr), .wr_data(wr_data), .wr_err(wr_err),
        .b_load(b_load), .b_payload(b_payload), .b_busy(b_busy)
    );

    axil_resp_slot #(.payload_t(axil_r_payload_t)) r_slot_inst (
        .aclk(aclk), .aresetn(aresetn),
        .load(r_load), .load_payload(r_payload),
        .valid(rvalid), .ready(rready), .payload(r_bus), .busy(r_busy)
    );

    axil_resp_slot #(.payload_t(axil_b_payload_t)) b_slot_inst (
        .aclk(aclk), .aresetn(aresetn),
        .load(b_load), .load_payload(b_payload),
        .valid(bvalid), .ready(bready), .payload(b_bus), .busy(b_busy)
    );

    timer_regs #(.BASE_ADDR(BASE_ADDR)) timer_regs_inst (
        .aclk(aclk), .aresetn(aresetn),
        .rd_strobe(rd_strobe), .rd_addr(rd_addr), .rd_data(rd_data), .rd_err(rd_err),
        .wr_strobe(wr_strobe), .wr_addr(wr_addr), .wr_data(wr_data), .wr_err(wr_err),
        .irq(irq)
    );

    assign rdata = r_bus.data;                 // Split the held payloads onto the bus
    assign rresp = r_bus.resp;
    assign bresp = b_bus.resp;

endmodule

/* hw/timer_regs.sv */
`timescale 1ns/1ps

module timer_regs import axil_pkg::*, timer_regmap_pkg::*; #(
    parameter logic [AXIL_ADDR_W-1:0] BASE_ADDR = '0   // Window base
) (
    input  logic                   aclk,       // Bus clock
    input  logic                   aresetn,    // Async reset, active low
    input  logic                   rd_strobe,  // Read access this cycle
    input  logic [AXIL_ADDR_W-1:0] rd_addr,    // Read byte address
    output logic [AXIL_DATA_W-1:0] rd_data,    // Read word, zero on miss
    output logic                   rd_err,     // Read decode miss
    input  logic                   wr_strobe,  // Write access this cycle
    input  logic [AXIL_ADDR_W-1:0] wr_addr,    // Write byte address
    input  logic [AXIL_DATA_W-1:0] wr_data,    // Write word
    output logic                   wr_err,     // Write decode miss
    output logic                   irq         // One-cycle wrap pulse
);

    logic                   ctrl_enable;       // Counter run bit
    logic                   ctrl_irq_en;       // Wrap interrupt enable
    logic [AXIL_DATA_W-1:0] count_q;           // Live counter, read as status
    logic [AXIL_DATA_W-1:0] period_q;          // data_0
    logic [AXIL_DATA_W-1:0] scratch_q;         // data_1
    logic [AXIL_DATA_W-1:0] ctrl_word;         // Control as seen on the bus
    reg_idx_t               rd_idx;            // Decoded read target
    reg_idx_t               wr_idx;            // Decoded write target
    logic                   wr_ok;             // Write hits a register
    logic                   status_wr;         // Reload of the counter
    logic                   wrap;              // Count at period while running

    // Offset match also rejects unaligned and out-of-window addresses
    function automatic logic addr_decode(input logic [AXIL_ADDR_W-1:0] addr,
                                         output reg_idx_t idx);
        logic [AXIL_ADDR_W-1:0] off;
        logic                   err;
        off = addr - BASE_ADDR;                // Below base wraps to a large offset
        err = 1'b0;
        idx = IDX_CONTROL;
        case (off)
            REG_CONTROL: idx = IDX_CONTROL;
            REG_STATUS:  idx = IDX_STATUS;
            REG_DATA_0:  idx = IDX_DATA_0;
            REG_DATA_1:  idx = IDX_DATA_1;
            default:     err = 1'b1;           // Not one of the four words
        endcase
        return err;
    endfunction

    always_comb begin
        rd_err = addr_decode(rd_addr, rd_idx);
        wr_err = addr_decode(wr_addr, wr_idx);
    end

    always_comb begin
        ctrl_word              = '0;
        ctrl_word[CTRL_ENABLE] = ctrl_enable;
        ctrl_word[CTRL_IRQ_EN] = ctrl_irq_en;
    end

    // Read mux stays quiet outside a strobed hit
    always_comb begin
        rd_data = '0;
        if (rd_strobe && !rd_err) begin
            case (rd_idx)
                IDX_CONTROL: rd_data = ctrl_word;
                IDX_STATUS:  rd_data = count_q;
                IDX_DATA_0:  rd_data = period_q;
                IDX_DATA_1:  rd_data = scratch_q;
                default:     rd_data = '0;
            endcase
        end
    end

    assign wr_ok     = wr_strobe && !wr_err;
    assign status_wr = wr_ok && (wr_idx == IDX_STATUS);
    assign wrap      = ctrl_enable && (count_q == period_q);

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            ctrl_enable <= 1'b0;
            ctrl_irq_en <= 1'b0;
            period_q    <= '0;
            scratch_q   <= '0;
        end else if (wr_ok) begin
            case (wr_idx)
                IDX_CONTROL: begin
                    ctrl_enable <= wr_data[CTRL_ENABLE];
                    ctrl_irq_en <= wr_data[CTRL_IRQ_EN];
                end
                IDX_DATA_0: period_q  <= wr_data;
                IDX_DATA_1: scratch_q <= wr_data;
                default: ;                     // Status handled by the counter
            endcase
        end
    end

    // A status reload wins over counting
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            count_q <= '0;
            irq     <= 1'b0;
        end else begin
            irq <= wrap && ctrl_irq_en && !status_wr;  // High the cycle after the wrap
            if (status_wr) begin
                count_q <= wr_data;
            end else if (wrap) begin
                count_q <= '0;                 // Period reached
            end else if (ctrl_enable) begin
                count_q <= count_q + 1'b1;
            end
        end
    end

    // A period of one or more leaves a gap between wraps
    assert property (@(posedge aclk) disable iff (!aresetn)
        irq |=> !irq)
        else $error("irq high two cycles");

endmodule

/* hw/axil_slave_fsm.sv */
`timescale 1ns/1ps

module axil_slave_fsm import axil_pkg::*; (
    input  logic                   aclk,       // Bus clock
    input  logic                   aresetn,    // Async reset, active low
    input  logic [AXIL_ADDR_W-1:0] araddr,     // Read address
    input  logic                   arvalid,    // Read address valid
    output logic                   arready,    // Read address ready pulse
    input  logic [AXIL_ADDR_W-1:0] awaddr,     // Write address
    input  logic                   awvalid,    // Write address valid
    output logic                   awready,    // Write address ready pulse
    input  logic [AXIL_DATA_W-1:0] wdata,      // Write data
    input  logic                   wvalid,     // Write data valid
    output logic                   wready,     // Write data ready pulse
    output logic                   rd_strobe,  // One-cycle register read
    output logic [AXIL_ADDR_W-1:0] rd_addr,    // Latched read address
    input  logic [AXIL_DATA_W-1:0] rd_data,    // Register bank read word
    input  logic                   rd_err,     // Read decode miss
    output logic                   r_load,     // Load read response slot
    output axil_r_payload_t        r_payload,  // Read response contents
    input  logic                   r_busy,     // Read slot still full
    output logic                   wr_strobe,  // One-cycle register write
    output logic [AXIL_ADDR_W-1:0] wr_addr,    // Latched write address
    output logic [AXIL_DATA_W-1:0] wr_data,    // Latched write data
    input  logic                   wr_err,     // Write decode miss
    output logic                   b_load,     // Load write response slot
    output axil_b_payload_t        b_payload,  // Write response contents
    input  logic                   b_busy      // Write slot still full
);

    typedef enum logic [1:0] {
        IDLE,                                  // Waiting for a request
        TRANSFER,                              // Ready pulse toward the master
        RESPONSE                               // Access issued, slot draining
    } state_t;

    state_t rd_state;                          // Read channel machine
    state_t wr_state;                          // Write channel machine

    // Read side
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            rd_state  <= IDLE;
            arready   <= 1'b0;
            rd_strobe <= 1'b0;
        end else begin
            case (rd_state)
                IDLE: begin
                    if (arvalid) begin
                        arready  <= 1'b1;      // Seen by the master on the next edge
                        rd_state <= TRANSFER;
                    end
                end
                TRANSFER: begin
                    arready   <= 1'b0;         // Single-cycle ready
                    rd_strobe <= 1'b1;         // Read the bank next cycle
                    rd_state  <= RESPONSE;
                end
                RESPONSE: begin
                    rd_strobe <= 1'b0;
                    if (!rd_strobe && !r_busy) begin
                        rd_state <= IDLE;      // Slot cleared this edge
                    end
                end
                default: begin
                    rd_state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (rd_state == IDLE && arvalid) begin
            rd_addr <= araddr;                 // Address is stable while arvalid holds
        end
    end

    // Write side, address and data taken together
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_state  <= IDLE;
            awready   <= 1'b0;
            wready    <= 1'b0;
            wr_strobe <= 1'b0;
        end else begin
            case (wr_state)
                IDLE: begin
                    if (awvalid && wvalid) begin
                        awready  <= 1'b1;      // Both readies pulse together
                        wready   <= 1'b1;
                        wr_state <= TRANSFER;
                    end
                end
                TRANSFER: begin
                    awready   <= 1'b0;
                    wready    <= 1'b0;
                    wr_strobe <= 1'b1;         // Bank updates on the following edge
                    wr_state  <= RESPONSE;
                end
                RESPONSE: begin
                    wr_strobe <= 1'b0;
                    if (!wr_strobe && !b_busy) begin
                        wr_state <= IDLE;
                    end
                end
                default: begin
                    wr_state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (wr_state == IDLE && awvalid && wvalid) begin
            wr_addr <= awaddr;                 // Capture address and word as a pair
            wr_data <= wdata;
        end
    end

    // Bank answers in the strobe cycle, so the slots load on the same edge
    assign r_load = rd_strobe;
    assign b_load = wr_strobe;

    always_comb begin
        r_payload.data = rd_data;              // Bank already zeroes a miss
        r_payload.resp = rd_err ? SLVERR : OKAY;
        b_payload.resp = wr_err ? SLVERR : OKAY;
    end

    // Address readies are pulses, never held across cycles
    assert property (@(posedge aclk) disable iff (!aresetn)
        arready |=> !arready)
        else $error("arready held two cycles");

    assert property (@(posedge aclk) disable iff (!aresetn)
        awready |=> !awready)
        else $error("awready held two cycles");

endmodule

/* hw/axil_resp_slot.sv */
`timescale 1ns/1ps

module axil_resp_slot #(
    parameter type payload_t = logic [1:0]    // Channel contents held here
) (
    input  logic     aclk,                    // Bus clock
    input  logic     aresetn,                 // Async reset, active low
    input  logic     load,                    // One-cycle capture request
    input  payload_t load_payload,            // Contents to capture
    output logic     valid,                   // Channel valid to the master
    input  logic     ready,                   // Channel ready from the master
    output payload_t payload,                 // Held contents on the bus
    output logic     busy                     // Slot still owes a handshake
);

    payload_t payload_q;                      // Captured contents

    // Valid rises on load and falls on the accepting edge
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            valid <= 1'b0;                    // Empty out of reset
        end else if (load) begin
            valid <= 1'b1;                    // New response present
        end else if (ready) begin
            valid <= 1'b0;                    // Master took it
        end
    end

    always_ff @(posedge aclk) begin
        if (load) begin
            payload_q <= load_payload;        // Latch once, hold until accepted
        end
    end

    assign payload = payload_q;               // Drive held contents
    assign busy    = valid && !ready;         // Drops on the edge the slot clears

    // A stalled response must not change under the master
    assert property (@(posedge aclk) disable iff (!aresetn)
        (valid && !ready) |=> (valid && $stable(payload)))
        else $error("response changed while stalled");

    // The state machine waits for the slot before it issues another access
    assert property (@(posedge aclk) disable iff (!aresetn)
        load |-> !busy)
        else $error("load while slot busy");

endmodule

/* hw/timer_regmap_pkg.sv */
package timer_regmap_pkg;

    // Byte offsets from the window base
    localparam logic [31:0] REG_CONTROL = 32'h0000_0000;  // Enable and irq enable
    localparam logic [31:0] REG_STATUS  = 32'h0000_0004;  // Live count, write reloads
    localparam logic [31:0] REG_DATA_0  = 32'h0000_0008;  // Timer period
    localparam logic [31:0] REG_DATA_1  = 32'h0000_000C;  // Scratch word

    // Bit positions inside the control word
    localparam int CTRL_ENABLE = 0;                       // Counter runs when set
    localparam int CTRL_IRQ_EN = 1;                       // Wrap raises irq when set

    // Decoded register select
    typedef enum logic [1:0] {
        IDX_CONTROL = 2'd0,                               // Control word
        IDX_STATUS  = 2'd1,                               // Counter
        IDX_DATA_0  = 2'd2,                               // Period
        IDX_DATA_1  = 2'd3                                // Scratch
    } reg_idx_t;

endpackage

/* hw/axil_pkg.sv */
package axil_pkg;

    // Bus geometry, shared by every block on the AXI4-Lite side
    localparam int AXIL_ADDR_W = 32;                  // Byte address width
    localparam int AXIL_DATA_W = 32;                  // Data word width

    // Response codes carried on rresp and bresp
    typedef enum logic [1:0] {
        OKAY   = 2'b00,                               // Access done
        SLVERR = 2'b10                                // Decode miss or bad alignment
    } axil_resp_t;

    // Read data channel contents, held in the read response slot
    typedef struct packed {
        logic [AXIL_DATA_W-1:0] data;                 // Read word, zero on error
        axil_resp_t             resp;                 // Read status
    } axil_r_payload_t;                               // 34 bits

    // Write response channel contents, held in the write response slot
    typedef struct packed {
        axil_resp_t resp;                             // Write status
    } axil_b_payload_t;                               // 2 bits

endpackage
